// ==== common/sprite_defines.svh ====
/*
 * sprite display parameters
 * 640x480 video timing, sprite geometry and sprite count
 */

`ifndef SPRITE_DEFINES_SVH
`define SPRITE_DEFINES_SVH

// screen coordinate width, covers 0..799
`define CORDW       10

// horizontal timing in pixels
`define H_ACTIVE    640
`define H_FP        16
`define H_SYNC      96
`define H_BP        48

// vertical timing in lines
`define V_ACTIVE    480
`define V_FP        10
`define V_SYNC      2
`define V_BP        33

// sprite bitmap is SPR_SIZE x SPR_SIZE, one bit per pixel
`define SPR_SIZE    8
`define SPR_SCALE   4   // integer scale in both directions
`define NUM_SPRITES 4   // default engine count, 1..8

`define COLW        12  // 4 bits per channel

`endif

// ==== common/sprite_pkg.sv ====
/*
 * sprite package
 * engine FSM states and host configuration opcodes
 */

package sprite_pkg;

    // sprite engine FSM
    typedef enum logic [1:0] {
        IDLE      = 2'd0,  // waiting for start on the sprite's first line
        WAIT_POS  = 2'd1,  // armed, waiting for sx to reach sprite x
        DRAW      = 2'd2,  // shifting out bitmap pixels
        NEXT_LINE = 2'd3   // row done, step line / row counters
    } sprite_state_e;

    // configuration write opcodes, 2 bits on cfg_op
    typedef enum logic [1:0] {
        SET_X      = 2'd0,  // staged x position
        SET_Y      = 2'd1,  // staged y position
        SET_COLOUR = 2'd2,  // staged 12-bit colour
        SET_ROW    = 2'd3   // bitmap row, written straight through
    } cfg_op_e;

endpackage

// ==== verilog/display_timing.sv ====
/*
 * display timing generator
 * 800x525 counters, negative syncs, data enable, line and frame strobes
 */

`timescale 1ns/100ps
`include "sprite_defines.svh"

module display_timing (
    input  wire logic              clk_pix,  // pixel clock
    input  wire logic              arst_n,
    output      logic [`CORDW-1:0] sx,       // horizontal position
    output      logic [`CORDW-1:0] sy,       // vertical position
    output      logic              hsync,
    output      logic              vsync,
    output      logic              de,       // active video
    output      logic              line,     // start of every line
    output      logic              frame     // start of vertical blank
);

    // horizontal decode points
    localparam logic [`CORDW-1:0] HA_END = `CORDW'(`H_ACTIVE);
    localparam logic [`CORDW-1:0] HS_STA = `CORDW'(`H_ACTIVE + `H_FP);
    localparam logic [`CORDW-1:0] HS_END = `CORDW'(`H_ACTIVE + `H_FP + `H_SYNC);
    localparam logic [`CORDW-1:0] H_LAST = `CORDW'(`H_ACTIVE + `H_FP + `H_SYNC + `H_BP - 1);

    // vertical decode points
    localparam logic [`CORDW-1:0] VA_END = `CORDW'(`V_ACTIVE);
    localparam logic [`CORDW-1:0] VS_STA = `CORDW'(`V_ACTIVE + `V_FP);
    localparam logic [`CORDW-1:0] VS_END = `CORDW'(`V_ACTIVE + `V_FP + `V_SYNC);
    localparam logic [`CORDW-1:0] V_LAST = `CORDW'(`V_ACTIVE + `V_FP + `V_SYNC + `V_BP - 1);

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin  // end of line
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // strobes straight off the registered counters
    always_comb begin
        hsync = !(sx >= HS_STA && sx < HS_END);  // active low
        vsync = !(sy >= VS_STA && sy < VS_END);
        de    = (sx < HA_END) && (sy < VA_END);
        line  = (sx == '0);
        frame = (sx == '0) && (sy == VA_END);   // first blank line
    end

endmodule

// ==== sprite/sprite_ctrl.sv ====
/*
 * sprite controller
 * decodes host writes, double-buffers position and colour, starts engines
 */

`timescale 1ns/100ps
`include "sprite_defines.svh"

module sprite_ctrl #(
    parameter int num_sprites = `NUM_SPRITES
) (
    input  wire logic                                   clk_pix,
    input  wire logic                                   arst_n,
    input  wire logic                                   cfg_we,    // one-cycle strobe
    input       sprite_pkg::cfg_op_e                    cfg_op,
    input  wire logic [2:0]                             cfg_sel,   // sprite index
    input  wire logic [15:0]                            cfg_data,
    input  wire logic                                   line,
    input  wire logic                                   frame,
    input  wire logic [`CORDW-1:0]                      sy,
    output      logic [num_sprites-1:0]                 spr_start,
    output      logic [num_sprites-1:0][`CORDW-1:0]     spr_x,
    output      logic [num_sprites-1:0][`COLW-1:0]      spr_colour,
    output      logic [num_sprites-1:0]                 row_we,
    output      logic [2:0]                             row_addr,
    output      logic [7:0]                             row_data
);

    // staged copies take host writes, live copies feed the engines
    logic [`CORDW-1:0] stage_x   [num_sprites];
    logic [`CORDW-1:0] stage_y   [num_sprites];
    logic [`COLW-1:0]  stage_col [num_sprites];
    logic [`CORDW-1:0] live_x    [num_sprites];
    logic [`CORDW-1:0] live_y    [num_sprites];
    logic [`COLW-1:0]  live_col  [num_sprites];

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_sprites; i++) begin
                stage_x[i]   <= '0;
                stage_y[i]   <= '0;
                stage_col[i] <= '0;  // black, sprite invisible
                live_x[i]    <= '0;
                live_y[i]    <= '0;
                live_col[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < num_sprites; i++) begin
                if (cfg_we && cfg_sel == 3'(i)) begin  // selects beyond count ignored
                    case (cfg_op)
                        sprite_pkg::SET_X:      stage_x[i]   <= cfg_data[`CORDW-1:0];
                        sprite_pkg::SET_Y:      stage_y[i]   <= cfg_data[`CORDW-1:0];
                        sprite_pkg::SET_COLOUR: stage_col[i] <= cfg_data[`COLW-1:0];
                        default: ;  // rows go straight to the engine
                    endcase
                end
                // swap at start of vblank so a frame never tears
                if (frame) begin
                    live_x[i]   <= stage_x[i];
                    live_y[i]   <= stage_y[i];
                    live_col[i] <= stage_col[i];
                end
            end
        end
    end

    always_comb begin
        row_addr = cfg_data[10:8];
        row_data = cfg_data[7:0];  // msb is leftmost pixel
        for (int i = 0; i < num_sprites; i++) begin
            spr_start[i]  = line && (sy == live_y[i]);  // first sprite line
            spr_x[i]      = live_x[i];
            spr_colour[i] = live_col[i];
            row_we[i]     = cfg_we && (cfg_op == sprite_pkg::SET_ROW) && (cfg_sel == 3'(i));
        end
    end

endmodule

// ==== sprite/sprite_engine.sv ====
/*
 * sprite engine
 * 8x8 one-bit bitmap drawn at spr_x, each pixel repeated SPR_SCALE times
 */

`timescale 1ns/100ps
`include "sprite_defines.svh"

module sprite_engine (
    input  wire logic              clk_pix,
    input  wire logic              arst_n,
    input  wire logic              start,     // line where sprite begins
    input  wire logic [`CORDW-1:0] sx,
    input  wire logic [`CORDW-1:0] spr_x,     // left edge
    input  wire logic              row_we,
    input  wire logic [2:0]        row_addr,
    input  wire logic [7:0]        row_data,
    output      logic              pix        // one cycle behind sx
);

    localparam int SCW = (`SPR_SCALE > 1) ? $clog2(`SPR_SCALE) : 1;
    localparam logic [SCW-1:0] SC_LAST  = SCW'(`SPR_SCALE - 1);
    localparam logic [2:0]     POS_LAST = 3'(`SPR_SIZE - 1);

    sprite_pkg::sprite_state_e state;
    logic [`SPR_SIZE-1:0] bitmap [`SPR_SIZE];
    logic [2:0]     bx, by;          // next bitmap column, current row
    logic [SCW-1:0] cx, cy;          // repeat counts within column / row
    logic [2:0]     cur_bx, cur_by;  // position of the pixel under sx
    logic [SCW-1:0] cur_cx;
    logic           hit;             // sx reached left edge this cycle
    logic           drawing;
    logic           last_col;
    logic           bit_on;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < `SPR_SIZE; r++) begin
                bitmap[r] <= '0;  // blank until written
            end
        end else if (row_we) begin
            bitmap[row_addr] <= row_data;
        end
    end

    always_comb begin
        cur_bx   = (state == sprite_pkg::DRAW && !start) ? bx : '0;
        cur_cx   = (state == sprite_pkg::DRAW && !start) ? cx : '0;
        cur_by   = start ? '0 : by;
        hit      = (start || state == sprite_pkg::WAIT_POS) && (sx == spr_x);
        drawing  = hit || (state == sprite_pkg::DRAW && !start);
        last_col = (cur_bx == POS_LAST) && (cur_cx == SC_LAST);
        bit_on   = bitmap[cur_by][POS_LAST - cur_bx];
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= sprite_pkg::IDLE;
            bx    <= '0;
            cx    <= '0;
            by    <= '0;
            cy    <= '0;
            pix   <= 1'b0;
        end else begin
            pix <= drawing && bit_on;
            if (start) begin  // restart from top row
                by <= '0;
                cy <= '0;
            end
            if (drawing) begin
                if (last_col) begin
                    state <= sprite_pkg::NEXT_LINE;
                    bx    <= '0;
                    cx    <= '0;
                end else if (cur_cx == SC_LAST) begin  // column repeated enough
                    state <= sprite_pkg::DRAW;
                    bx    <= cur_bx + 3'd1;
                    cx    <= '0;
                end else begin
                    state <= sprite_pkg::DRAW;
                    bx    <= cur_bx;
                    cx    <= cur_cx + 1'b1;
                end
            end else if (start) begin
                state <= sprite_pkg::WAIT_POS;
            end else if (state == sprite_pkg::NEXT_LINE) begin
                state <= sprite_pkg::WAIT_POS;  // left edge comes round next line
                if (cy != SC_LAST) begin
                    cy <= cy + 1'b1;  // same row again
                end else if (by != POS_LAST) begin
                    cy <= '0;
                    by <= by + 3'd1;
                end else begin
                    cy    <= '0;
                    by    <= '0;
                    state <= sprite_pkg::IDLE;  // bottom row done
                end
            end
        end
    end

endmodule

// ==== sprite/sprite_compositor.sv ====
/*
 * sprite compositor
 * lowest-index opaque sprite wins, blanked colour, syncs aligned to rgb
 */

`timescale 1ns/100ps
`include "sprite_defines.svh"

module sprite_compositor #(
    parameter int num_sprites = `NUM_SPRITES
) (
    input  wire logic                              clk_pix,
    input  wire logic                              arst_n,
    input  wire logic [num_sprites-1:0]            spr_pix,     // already 1 cycle late
    input  wire logic [num_sprites-1:0][`COLW-1:0] spr_colour,
    input  wire logic                              de_in,       // straight from timing
    input  wire logic                              hsync_in,
    input  wire logic                              vsync_in,
    output      logic [`COLW-1:0]                  rgb,
    output      logic                              hsync,
    output      logic                              vsync,
    output      logic                              de
);

    logic [`COLW-1:0] pick;  // winning colour
    logic [1:0]       de_q;  // two-stage delay lines
    logic [1:0]       hs_q;
    logic [1:0]       vs_q;

    // walk from highest index down so sprite 0 ends on top
    always_comb begin
        pick = '0;
        for (int i = num_sprites - 1; i >= 0; i--) begin
            if (spr_pix[i]) pick = spr_colour[i];
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            de_q <= '0;
            hs_q <= '1;  // syncs idle high
            vs_q <= '1;
            rgb  <= '0;
        end else begin
            de_q <= {de_q[0], de_in};
            hs_q <= {hs_q[0], hsync_in};
            vs_q <= {vs_q[0], vsync_in};
            rgb  <= de_q[0] ? pick : '0;  // de_q[0] lines up with spr_pix
        end
    end

    assign de    = de_q[1];
    assign hsync = hs_q[1];
    assign vsync = vs_q[1];

endmodule

// ==== verilog/sprite_display_top.sv ====
/*
 * sprite display top
 * timing, sprite controller, engine array and compositor
 */

`timescale 1ns/100ps
`include "sprite_defines.svh"

module sprite_display_top #(
    parameter int num_sprites = `NUM_SPRITES
) (
    input  wire logic             clk_pix,
    input  wire logic             arst_n,
    input  wire logic             cfg_we,
    input       sprite_pkg::cfg_op_e cfg_op,
    input  wire logic [2:0]       cfg_sel,
    input  wire logic [15:0]      cfg_data,
    output      logic [`COLW-1:0] rgb,    // 2 cycles behind counters
    output      logic             hsync,
    output      logic             vsync,
    output      logic             de
);

    // raw timing
    logic [`CORDW-1:0] sx, sy;
    logic              hsync_t, vsync_t, de_t;
    logic              line, frame;

    // controller to engines and compositor
    logic [num_sprites-1:0]             spr_start;
    logic [num_sprites-1:0][`CORDW-1:0] spr_x;
    logic [num_sprites-1:0][`COLW-1:0]  spr_colour;
    logic [num_sprites-1:0]             row_we;
    logic [2:0]                         row_addr;
    logic [7:0]                         row_data;
    logic [num_sprites-1:0]             spr_pix;

    display_timing u_timing (
        .clk_pix,
        .arst_n,
        .sx,
        .sy,
        .hsync (hsync_t),
        .vsync (vsync_t),
        .de    (de_t),
        .line,
        .frame
    );

    sprite_ctrl #(.num_sprites(num_sprites)) u_ctrl (
        .clk_pix,
        .arst_n,
        .cfg_we,
        .cfg_op,
        .cfg_sel,
        .cfg_data,
        .line,
        .frame,
        .sy,
        .spr_start,
        .spr_x,
        .spr_colour,
        .row_we,
        .row_addr,
        .row_data
    );

    // one engine per sprite, bitmap rows broadcast with per-engine strobe
    for (genvar i = 0; i < num_sprites; i++) begin : g_engine
        sprite_engine u_engine (
            .clk_pix,
            .arst_n,
            .start    (spr_start[i]),
            .sx,
            .spr_x    (spr_x[i]),
            .row_we   (row_we[i]),
            .row_addr,
            .row_data,
            .pix      (spr_pix[i])
        );
    end

    sprite_compositor #(.num_sprites(num_sprites)) u_comp (
        .clk_pix,
        .arst_n,
        .spr_pix,
        .spr_colour,
        .de_in    (de_t),
        .hsync_in (hsync_t),
        .vsync_in (vsync_t),
        .rgb,
        .hsync,
        .vsync,
        .de
    );

endmodule

// ==== testbench/sprite_display_properties.sv ====
/*
 * video output properties
 * blanking colour, hsync width and de/vsync exclusion at the top level
 */

`timescale 1ns/100ps
`include "sprite_defines.svh"

module sprite_display_properties (
    input logic             clk_pix,
    input logic             arst_n,
    input logic [`COLW-1:0] rgb,
    input logic             hsync,
    input logic             vsync,
    input logic             de
);

    logic [7:0] hs_len;  // low cycles of the current hsync pulse

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) hs_len <= '0;
        else if (!hsync) hs_len <= hs_len + 8'd1;
        else hs_len <= '0;
    end

    blank_is_black: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !de |-> rgb == '0) else $error("rgb not black outside active video");

    hsync_width: assert property (@(posedge clk_pix) disable iff (!arst_n)
        $rose(hsync) |-> hs_len == 8'(`H_SYNC)) else $error("hsync pulse has wrong width");

    no_de_in_vsync: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !vsync |-> !de) else $error("de high during vsync");

endmodule

bind sprite_display_top sprite_display_properties u_props (
    .clk_pix (clk_pix),
    .arst_n  (arst_n),
    .rgb     (rgb),
    .hsync   (hsync),
    .vsync   (vsync),
    .de      (de)
);

// ==== testbench/sprite_display_tb.sv ====
/*
 * sprite display testbench
 * pattern-driven sprite setup, reference pixel model, reset and timing checks
 */

`timescale 1ns/100ps
`include "sprite_defines.svh"

module sprite_display_tb;

    localparam int NUM       = `NUM_SPRITES;
    localparam int SPAN      = `SPR_SIZE * `SPR_SCALE;  // drawn size in pixels
    localparam int H_TOTAL   = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int V_TOTAL   = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam int MAX_REC   = 32;

    logic                clk_pix;
    logic                arst_n;
    logic                cfg_we;
    sprite_pkg::cfg_op_e cfg_op;
    logic [2:0]          cfg_sel;
    logic [15:0]         cfg_data;
    logic [`COLW-1:0]    rgb;
    logic                hsync;
    logic                vsync;
    logic                de;

    // reference model, staged and live copies as seen by software
    int               stg_x    [NUM];
    int               stg_y    [NUM];
    logic [`COLW-1:0] stg_col  [NUM];
    int               live_x   [NUM];
    int               live_y   [NUM];
    logic [`COLW-1:0] live_col [NUM];
    logic [7:0]       bmp      [NUM][`SPR_SIZE];

    logic [15:0] pat [4*MAX_REC];  // op, sel, data, frames per record
    int   errors = 0;
    int   passed = 0;
    int   failed = 0;
    int   cycles = 0;
    int   limit  = 0;  // 0 until the pattern file is sized
    event vs_fall;

    // output-side position tracking
    int   px = 0;
    int   py = 0;
    int   hs_low = 0;
    int   vs_low = 0;
    int   hs_pulses = 0;
    logic de_d = 1'b0;
    logic hs_d = 1'b1;
    logic vs_d = 1'b1;
    logic seen = 1'b0;  // first vsync seen, frame counts valid

    sprite_display_top dut_i (
        .clk_pix,
        .arst_n,
        .cfg_we,
        .cfg_op,
        .cfg_sel,
        .cfg_data,
        .rgb,
        .hsync,
        .vsync,
        .de
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;  // 100 MHz stand-in for the pixel clock
    end

    always @(posedge clk_pix) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: no result after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // colour of pixel (x, y) from the live model, lowest index on top
    function automatic logic [`COLW-1:0] expected_colour(input int x, input int y);
        int               dx;
        int               dy;
        logic [`COLW-1:0] c;
        logic             found;
        c     = '0;
        found = 1'b0;
        for (int i = 0; i < NUM; i++) begin
            dx = x - live_x[i];
            dy = y - live_y[i];
            if (!found && dx >= 0 && dx < SPAN && dy >= 0 && dy < SPAN) begin
                if (bmp[i][dy / `SPR_SCALE][`SPR_SIZE - 1 - dx / `SPR_SCALE]) begin
                    c     = live_col[i];
                    found = 1'b1;
                end
            end
        end
        return c;
    endfunction

    // one host write, model follows the same field rules
    task automatic write_config(input logic [15:0] op_w, input logic [2:0] sel,
                                input logic [15:0] data);
        int s;
        s = int'(sel);
        @(posedge clk_pix);
        cfg_we   <= 1'b1;
        cfg_op   <= sprite_pkg::cfg_op_e'(op_w[1:0]);
        cfg_sel  <= sel;
        cfg_data <= data;
        @(posedge clk_pix);
        cfg_we   <= 1'b0;
        if (s < NUM) begin
            case (sprite_pkg::cfg_op_e'(op_w[1:0]))
                sprite_pkg::SET_X:      stg_x[s]   = int'(data[`CORDW-1:0]);
                sprite_pkg::SET_Y:      stg_y[s]   = int'(data[`CORDW-1:0]);
                sprite_pkg::SET_COLOUR: stg_col[s] = data[`COLW-1:0];
                default:                bmp[s][int'(data[10:8])] = data[7:0];  // immediate
            endcase
        end
    endtask

    task automatic check_reset_outputs();
        assert (de == 1'b0) else begin
            errors++;
            $display("Fail t=%0t de expected 0 got %b", $time, de);
        end
        assert (hsync == 1'b1 && vsync == 1'b1) else begin
            errors++;
            $display("Fail t=%0t hsync/vsync expected 1/1 got %b/%b", $time, hsync, vsync);
        end
        assert (rgb == '0) else begin
            errors++;
            $display("Fail t=%0t rgb expected %h got %h", $time, {`COLW{1'b0}}, rgb);
        end
    endtask

    task automatic finish_test(input int num, input int base);
        int n;
        n = errors - base;
        if (n == 0) passed++;
        else failed++;
        $display("test %0d %s, %0d errors", num, (n == 0) ? "ok" : "FAILING", n);
    endtask

    // sampled on the falling edge, away from the DUT's update edge
    always @(negedge clk_pix) begin : monitor
        logic [`COLW-1:0] want;
        if (arst_n) begin
            if (de) begin
                want = expected_colour(px, py);
                assert (rgb == want) else begin
                    errors++;
                    $display("Fail t=%0t rgb expected %h got %h at x %0d y %0d",
                             $time, want, rgb, px, py);
                end
                px++;
            end else if (de_d) begin  // active line just ended
                assert (px == `H_ACTIVE) else begin
                    errors++;
                    $display("Fail t=%0t de cycles per line expected %0d got %0d",
                             $time, `H_ACTIVE, px);
                end
                px = 0;
                py++;
                if (py == `V_ACTIVE) begin  // vblank starts, staged goes live
                    for (int i = 0; i < NUM; i++) begin
                        live_x[i]   = stg_x[i];
                        live_y[i]   = stg_y[i];
                        live_col[i] = stg_col[i];
                    end
                end
            end
            if (!hsync) hs_low++;
            else if (!hs_d) begin
                assert (hs_low == `H_SYNC) else begin
                    errors++;
                    $display("Fail t=%0t hsync low cycles expected %0d got %0d",
                             $time, `H_SYNC, hs_low);
                end
                hs_low = 0;
                hs_pulses++;
            end
            if (!vsync) vs_low++;
            if (!vsync && vs_d) begin
                if (seen) begin  // a whole frame lies behind us
                    assert (py == `V_ACTIVE) else begin
                        errors++;
                        $display("Fail t=%0t de lines expected %0d got %0d",
                                 $time, `V_ACTIVE, py);
                    end
                    assert (hs_pulses == V_TOTAL) else begin
                        errors++;
                        $display("Fail t=%0t hsync pulses expected %0d got %0d",
                                 $time, V_TOTAL, hs_pulses);
                    end
                end
                seen      = 1'b1;
                py        = 0;
                hs_pulses = 0;
                -> vs_fall;
            end else if (vsync && !vs_d) begin
                assert (vs_low == `V_SYNC * H_TOTAL) else begin
                    errors++;
                    $display("Fail t=%0t vsync low cycles expected %0d got %0d",
                             $time, `V_SYNC * H_TOTAL, vs_low);
                end
                vs_low = 0;
            end
            de_d = de;
            hs_d = hsync;
            vs_d = vsync;
        end
    end

    initial begin : main
        int          r;
        int          total_frames;
        int          tnum;
        int          base;
        int unsigned delay;
        arst_n   = 1'b0;
        cfg_we   = 1'b0;
        cfg_op   = sprite_pkg::SET_X;
        cfg_sel  = 3'd0;
        cfg_data = 16'h0000;
        void'($urandom(32'h6f12));
        for (int i = 0; i < NUM; i++) begin
            stg_x[i]    = 0;
            stg_y[i]    = 0;
            stg_col[i]  = '0;
            live_x[i]   = 0;
            live_y[i]   = 0;
            live_col[i] = '0;
            for (int j = 0; j < `SPR_SIZE; j++) bmp[i][j] = 8'h00;
        end
        for (int i = 0; i < 4*MAX_REC; i++) pat[i] = 16'h00ff;  // end marker fill
        $readmemh("testbench/sprite_patterns.txt", pat);
        total_frames = 0;
        r = 0;
        while (r < MAX_REC && pat[4*r] != 16'h00ff) begin
            total_frames += int'(pat[4*r+3]);
            r++;
        end
        limit = (total_frames + 2) * FRAME_CYC;  // +2 covers reset and frame test

        // test 1: outputs idle through reset and just after
        base = errors;
        repeat (10) begin
            @(negedge clk_pix);
            check_reset_outputs();
        end
        @(posedge clk_pix);
        arst_n <= 1'b1;
        repeat (2) begin
            @(negedge clk_pix);
            check_reset_outputs();
        end
        finish_test(1, base);

        // test 2: one whole frame of structure checks
        @(vs_fall);
        base = errors;
        @(vs_fall);
        finish_test(2, base);

        // pattern tests, each write lands right after a vsync edge
        tnum = 3;
        base = errors;
        r    = 0;
        while (r < MAX_REC && pat[4*r] != 16'h00ff) begin
            if (pat[4*r][4]) begin  // push the write into active video
                // lands on line 1 to 81, above or inside sprite 0
                delay = 28800 + ($urandom % 64000);
                repeat (delay) @(posedge clk_pix);
            end
            write_config(pat[4*r], pat[4*r+1][2:0], pat[4*r+2]);
            if (pat[4*r+3] != 16'h0000) begin
                repeat (int'(pat[4*r+3])) @(vs_fall);
                finish_test(tnum, base);
                tnum++;
                base = errors;
            end
            r++;
        end

        $display("%0d tests, %0d ok, %0d failing, %0d errors", passed + failed,
                 passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== testbench/sprite_patterns.txt ====
// columns: op sel data frames, all hex; op bit 4 moves the write into active video
// a nonzero frames column closes a test; op ff ends the list
0 0 0064 0   // sprite 0 x = 100
1 0 003c 0   // y = 60
2 0 0f80 0
3 0 0018 0
3 0 013c 0
3 0 027e 0
3 0 03ff 0
3 0 04e7 0
3 0 057e 0
3 0 063c 0
3 0 0718 3
0 2 006e 0   // sprite 2 overlaps sprite 0
1 2 0046 0
2 2 000f 0
3 2 00ff 0
3 2 03f0 0
3 2 07aa 3
10 0 00c8 0  // x moved mid-frame
2 0 00f0 3   // colour one cycle later
ff 0 0000 0

// ==== flist.f ====
+incdir+common
common/sprite_pkg.sv
verilog/display_timing.sv
sprite/sprite_ctrl.sv
sprite/sprite_engine.sv
sprite/sprite_compositor.sv
verilog/sprite_display_top.sv
testbench/sprite_display_properties.sv
testbench/sprite_display_tb.sv

// ==== Makefile ====
# sprite display simulation with Verilator

SRCS := $(shell grep -v '^+' flist.f) common/sprite_defines.svh

obj_dir/Vsprite_display_tb: flist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module sprite_display_tb -f flist.f

run: obj_dir/Vsprite_display_tb testbench/sprite_patterns.txt
	obj_dir/Vsprite_display_tb > sim.log 2>&1; cat sim.log
	@grep -q "Test completed successfully" sim.log || (echo "simulation FAILED"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
